/* rvs_pkg.sv */
package rvs_pkg;

    // datapath widths
    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // host bus map, byte addresses
    localparam int WB_ADR_W = 9;
    localparam logic [WB_ADR_W-1:0] ISSUE_ADR  = 9'h000; // write: instr in bits 31:0
    localparam logic [WB_ADR_W-1:0] STATUS_ADR = 9'h008; // read: busy/halted/illegal/retired
    localparam logic [WB_ADR_W-1:0] REGS_BASE  = 9'h100; // x0, xn at +8n

    // major opcodes
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10 // lui
    } alu_op_e;

    // how write-back widens the raw result
    typedef enum logic {
        ext_none = 1'b0, // keep all 64 bits
        ext_word = 1'b1  // sign-extend from bit 31
    } res_ext_e;

endpackage

/* rvs_regfile.sv */
`timescale 1ns/1ps

module rvs_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] raddr_h,
    output logic [rvs_pkg::XLEN-1:0]       rdata_a,
    output logic [rvs_pkg::XLEN-1:0]       rdata_b,
    output logic [rvs_pkg::XLEN-1:0]       rdata_h,
    input  logic                          wen,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rvs_pkg::XLEN-1:0]       wdata
);
    import rvs_pkg::*;

    logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // index 0 reads zero on every port
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];
    assign rdata_h = (raddr_h == '0) ? '0 : regs[raddr_h]; // host dump port

endmodule

/* rvs_decode.sv */
`timescale 1ns/1ps

module rvs_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           issue_valid,
    input  logic [31:0]                    issue_instr,
    output logic [rvs_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rvs_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rvs_pkg::XLEN-1:0]       rs1_data,
    input  logic [rvs_pkg::XLEN-1:0]       rs2_data,
    input  logic                           byp_wen,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] byp_waddr,
    input  logic [rvs_pkg::XLEN-1:0]       byp_wdata,
    output logic                           d_valid,
    output rvs_pkg::alu_op_e               d_alu_op,
    output logic [rvs_pkg::XLEN-1:0]       d_op_a,
    output logic [rvs_pkg::XLEN-1:0]       d_op_b,
    output logic [rvs_pkg::REG_ADDR_W-1:0] d_rd,
    output logic                           d_wen,
    output rvs_pkg::res_ext_e              d_res_ext,
    output logic                           d_ebreak,
    output logic                           d_illegal
);
    import rvs_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i, imm_u, shamt6, shamt5;
    logic [XLEN-1:0] src1, src2;
    alu_op_e         op;
    res_ext_e        ext;
    logic [XLEN-1:0] op_b;
    logic            wen, ebreak, illegal;

    assign opcode   = issue_instr[6:0];
    assign funct3   = issue_instr[14:12];
    assign funct7   = issue_instr[31:25];
    assign rs1_addr = issue_instr[19:15];
    assign rs2_addr = issue_instr[24:20];

    assign imm_i  = {{52{issue_instr[31]}}, issue_instr[31:20]};
    assign imm_u  = {{32{issue_instr[31]}}, issue_instr[31:12], 12'b0};
    assign shamt6 = {58'b0, issue_instr[25:20]}; // 64-bit shifts
    assign shamt5 = {59'b0, issue_instr[24:20]}; // word shifts

    // forward the write committed this cycle
    assign src1 = (byp_wen && byp_waddr == rs1_addr && rs1_addr != '0) ? byp_wdata : rs1_data;
    assign src2 = (byp_wen && byp_waddr == rs2_addr && rs2_addr != '0) ? byp_wdata : rs2_data;

    always_comb begin
        op      = alu_add;
        ext     = ext_none;
        op_b    = src2;
        wen     = 1'b1;
        ebreak  = 1'b0;
        illegal = 1'b0;
        case (opcode)
            OPC_LUI: begin
                op   = alu_pass_b;
                op_b = imm_u;
            end
            OPC_OP_IMM: begin
                op_b = imm_i;
                case (funct3)
                    3'b000: op = alu_add;
                    3'b010: op = alu_slt;
                    3'b011: op = alu_sltu;
                    3'b100: op = alu_xor;
                    3'b110: op = alu_or;
                    3'b111: op = alu_and;
                    3'b001: begin
                        op      = alu_sll;
                        op_b    = shamt6;
                        illegal = (funct7[6:1] != 6'b000000);
                    end
                    default: begin // srli / srai
                        op      = funct7[5] ? alu_sra : alu_srl;
                        op_b    = shamt6;
                        illegal = ({funct7[6], funct7[4:1]} != 5'b0);
                    end
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = alu_add;
                    10'b0100000_000: op = alu_sub;
                    10'b0000000_001: op = alu_sll;
                    10'b0000000_010: op = alu_slt;
                    10'b0000000_011: op = alu_sltu;
                    10'b0000000_100: op = alu_xor;
                    10'b0000000_101: op = alu_srl;
                    10'b0100000_101: op = alu_sra;
                    10'b0000000_110: op = alu_or;
                    10'b0000000_111: op = alu_and;
                    default:         illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM_32: begin
                ext = ext_word;
                case ({funct7, funct3}) inside
                    10'b???????_000: begin // addiw, funct7 is immediate
                        op   = alu_add;
                        op_b = imm_i;
                    end
                    10'b0000000_001: begin
                        op   = alu_sll;
                        op_b = shamt5;
                    end
                    10'b0000000_101: begin
                        op   = alu_srl;
                        op_b = shamt5;
                    end
                    10'b0100000_101: begin
                        op   = alu_sra;
                        op_b = shamt5;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            OPC_OP_32: begin
                ext = ext_word;
                case ({funct7, funct3})
                    10'b0000000_000: op = alu_add;
                    10'b0100000_000: op = alu_sub;
                    10'b0000000_001: op = alu_sll;
                    10'b0000000_101: op = alu_srl;
                    10'b0100000_101: op = alu_sra;
                    default:         illegal = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                wen     = 1'b0;
                ebreak  = (issue_instr == 32'h0010_0073);
                illegal = !ebreak; // only ebreak here
            end
            default: illegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid   <= 1'b0;
            d_wen     <= 1'b0;
            d_ebreak  <= 1'b0;
            d_illegal <= 1'b0;
        end else begin
            d_valid   <= issue_valid && !illegal; // dropped ops never retire
            d_wen     <= issue_valid && !illegal && wen;
            d_ebreak  <= issue_valid && ebreak;
            d_illegal <= issue_valid && illegal; // one-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            d_alu_op  <= op;
            d_op_a    <= src1;
            d_op_b    <= op_b;
            d_rd      <= issue_instr[11:7];
            d_res_ext <= ext;
        end
    end

endmodule

/* rvs_execute.sv */
`timescale 1ns/1ps

module rvs_execute (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           d_valid,
    input  rvs_pkg::alu_op_e               d_alu_op,
    input  logic [rvs_pkg::XLEN-1:0]       d_op_a,
    input  logic [rvs_pkg::XLEN-1:0]       d_op_b,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] d_rd,
    input  logic                           d_wen,
    input  rvs_pkg::res_ext_e              d_res_ext,
    input  logic                           d_ebreak,
    output logic                           e_valid,
    output logic [rvs_pkg::XLEN-1:0]       e_result,
    output logic [rvs_pkg::REG_ADDR_W-1:0] e_rd,
    output logic                           e_wen,
    output rvs_pkg::res_ext_e              e_res_ext,
    output logic                           e_ebreak
);
    import rvs_pkg::*;

    logic            word;
    logic [5:0]      shamt;
    logic [XLEN-1:0] srl_src, sra_src;
    logic [XLEN-1:0] result;

    assign word  = (d_res_ext == ext_word);
    assign shamt = word ? {1'b0, d_op_b[4:0]} : d_op_b[5:0]; // rs2 masked as well

    // word right shifts work on the low word only
    assign srl_src = word ? {32'b0, d_op_a[31:0]} : d_op_a;
    assign sra_src = word ? {{32{d_op_a[31]}}, d_op_a[31:0]} : d_op_a;

    always_comb begin
        case (d_alu_op)
            alu_add:    result = d_op_a + d_op_b;
            alu_sub:    result = d_op_a - d_op_b;
            alu_sll:    result = d_op_a << shamt;
            alu_slt:    result = {63'b0, $signed(d_op_a) < $signed(d_op_b)};
            alu_sltu:   result = {63'b0, d_op_a < d_op_b};
            alu_xor:    result = d_op_a ^ d_op_b;
            alu_srl:    result = srl_src >> shamt;
            alu_sra:    result = $unsigned($signed(sra_src) >>> shamt);
            alu_or:     result = d_op_a | d_op_b;
            alu_and:    result = d_op_a & d_op_b;
            alu_pass_b: result = d_op_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid  <= 1'b0;
            e_wen    <= 1'b0;
            e_ebreak <= 1'b0;
        end else begin
            e_valid  <= d_valid;
            e_wen    <= d_valid && d_wen;
            e_ebreak <= d_valid && d_ebreak;
        end
    end

    // raw result, widened in write-back
    always_ff @(posedge clk) begin
        e_result  <= result;
        e_rd      <= d_rd;
        e_res_ext <= d_res_ext;
    end

endmodule

/* rvs_writeback.sv */
`timescale 1ns/1ps

module rvs_writeback (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           e_valid,
    input  logic [rvs_pkg::XLEN-1:0]       e_result,
    input  logic [rvs_pkg::REG_ADDR_W-1:0] e_rd,
    input  logic                           e_wen,
    input  rvs_pkg::res_ext_e              e_res_ext,
    input  logic                           e_ebreak,
    output logic                           rf_wen,
    output logic [rvs_pkg::REG_ADDR_W-1:0] rf_waddr,
    output logic [rvs_pkg::XLEN-1:0]       rf_wdata,
    output logic [31:0]                    retired,
    output logic                           halted
);
    import rvs_pkg::*;

    // x0 stays read only
    assign rf_wen   = e_valid && e_wen && (e_rd != '0);
    assign rf_waddr = e_rd;

    always_comb begin
        case (e_res_ext)
            ext_word: rf_wdata = {{32{e_result[31]}}, e_result[31:0]}; // addw, sraw etc
            default:  rf_wdata = e_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired <= '0;
            halted  <= 1'b0;
        end else if (e_valid) begin
            retired <= retired + 32'd1; // ebreak counts too
            if (e_ebreak) begin
                halted <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

/* rvs_core_top.sv */
`timescale 1ns/1ps

module rvs_core_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [rvs_pkg::WB_ADR_W-1:0] adr,
    input  logic [rvs_pkg::XLEN-1:0]     dat_w,
    output logic [rvs_pkg::XLEN-1:0]     dat_r,
    output logic                         ack
);
    import rvs_pkg::*;

    logic                  req, reg_hit, halt_pend, busy, illegal_q;
    logic                  issue_valid;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, rdata_h, status;
    logic                  d_valid, d_wen, d_ebreak, d_illegal;
    alu_op_e               d_alu_op;
    logic [XLEN-1:0]       d_op_a, d_op_b;
    logic [REG_ADDR_W-1:0] d_rd, e_rd, rf_waddr;
    res_ext_e              d_res_ext, e_res_ext;
    logic                  e_valid, e_wen, e_ebreak;
    logic [XLEN-1:0]       e_result, rf_wdata;
    logic                  rf_wen, halted;
    logic [31:0]           retired;

    assign req     = cyc && stb;
    assign reg_hit = (adr[WB_ADR_W-1:REG_ADDR_W+3] == REGS_BASE[WB_ADR_W-1:REG_ADDR_W+3])
                     && (adr[2:0] == 3'b0);

    // an ebreak in flight already blocks issue
    assign halt_pend   = halted || (e_valid && e_ebreak);
    assign issue_valid = ack && req && we && (adr == ISSUE_ADR) && !halt_pend;

    assign busy   = d_valid || e_valid; // write-back commits at the end of e_valid
    assign status = {retired, 29'b0, illegal_q || d_illegal, halted, busy};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            ack       <= req && !ack; // single-cycle registered ack
            illegal_q <= illegal_q || d_illegal;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            if (!we && adr == STATUS_ADR) begin
                dat_r <= status;
            end else if (!we && reg_hit) begin
                dat_r <= rdata_h;
            end else begin
                dat_r <= '0;
            end
        end
    end

    rvs_decode rvs_decode_i (
        .clk, .rst_n,
        .issue_valid, .issue_instr(dat_w[31:0]),
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .byp_wen(rf_wen), .byp_waddr(rf_waddr), .byp_wdata(rf_wdata),
        .d_valid, .d_alu_op, .d_op_a, .d_op_b, .d_rd, .d_wen, .d_res_ext,
        .d_ebreak, .d_illegal
    );

    rvs_execute rvs_execute_i (
        .clk, .rst_n,
        .d_valid, .d_alu_op, .d_op_a, .d_op_b, .d_rd, .d_wen, .d_res_ext, .d_ebreak,
        .e_valid, .e_result, .e_rd, .e_wen, .e_res_ext, .e_ebreak
    );

    rvs_writeback rvs_writeback_i (
        .clk, .rst_n,
        .e_valid, .e_result, .e_rd, .e_wen, .e_res_ext, .e_ebreak,
        .rf_wen, .rf_waddr, .rf_wdata, .retired, .halted
    );

    rvs_regfile rvs_regfile_i (
        .clk, .rst_n,
        .raddr_a(rs1_addr), .raddr_b(rs2_addr), .raddr_h(adr[REG_ADDR_W+2:3]),
        .rdata_a(rs1_data), .rdata_b(rs2_data), .rdata_h,
        .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
    );

endmodule

/* tb_rvs_checker.sv */
`timescale 1ns/1ps

module tb_rvs_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cyc,
    input  logic                         stb,
    input  logic                         we,
    input  logic [rvs_pkg::WB_ADR_W-1:0] adr,
    input  logic [rvs_pkg::XLEN-1:0]     dat_w,
    input  logic [rvs_pkg::XLEN-1:0]     dat_r,
    input  logic                         ack,
    output int                           checks,
    output int                           errors
);
    import rvs_pkg::*;

    logic [XLEN-1:0] model_regs [NUM_REGS]; // architectural state
    logic            model_halted, model_illegal;
    logic [31:0]     model_retired;
    int              since_entry; // edges since an instr last entered decode, capped at 4
    int              req_wait;    // edges the open request has waited for ack

    // one instruction per RV64I rules, ok low for anything unsupported
    function automatic void isa_exec(input logic [31:0] ins, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                                     output logic ok);
        logic [XLEN-1:0] imm, ob;
        logic [31:0]     w;
        logic [9:0]      sel;
        imm = {{52{ins[31]}}, ins[31:20]};
        ok  = 1'b1;
        res = '0;
        w   = '0;
        case (ins[6:0])
            OPC_LUI: res = {{32{ins[31]}}, ins[31:12], 12'h000};
            OPC_OP_IMM, OPC_OP: begin
                ob  = (ins[6:0] == OPC_OP) ? b : imm;
                sel = {ins[31:25], ins[14:12]};
                if (ins[6:0] == OPC_OP_IMM) begin
                    // funct7 only qualifies shifts, shamt[5] lives in bit 25
                    sel[9:3] = (ins[13:12] == 2'b01) ? {ins[31:26], 1'b0} : 7'h00;
                end
                case (sel)
                    {7'h00, 3'd0}: res = a + ob;
                    {7'h20, 3'd0}: res = a - ob;
                    {7'h00, 3'd1}: res = a << ob[5:0];
                    {7'h00, 3'd2}: res = {63'b0, $signed(a) < $signed(ob)};
                    {7'h00, 3'd3}: res = {63'b0, a < ob};
                    {7'h00, 3'd4}: res = a ^ ob;
                    {7'h00, 3'd5}: res = a >> ob[5:0];
                    {7'h20, 3'd5}: res = $signed(a) >>> ob[5:0];
                    {7'h00, 3'd6}: res = a | ob;
                    {7'h00, 3'd7}: res = a & ob;
                    default:       ok = 1'b0;
                endcase
            end
            OPC_OP_IMM_32, OPC_OP_32: begin
                ob  = (ins[6:0] == OPC_OP_32) ? b : imm;
                sel = {ins[31:25], ins[14:12]};
                if (ins[6:0] == OPC_OP_IMM_32 && ins[14:12] == 3'd0) begin
                    sel = '0; // addiw, upper bits are immediate
                end
                case (sel)
                    {7'h00, 3'd0}: w = a[31:0] + ob[31:0];
                    {7'h20, 3'd0}: w = a[31:0] - ob[31:0];
                    {7'h00, 3'd1}: w = a[31:0] << ob[4:0];
                    {7'h00, 3'd5}: w = a[31:0] >> ob[4:0];
                    {7'h20, 3'd5}: w = $signed(a[31:0]) >>> ob[4:0];
                    default:       ok = 1'b0;
                endcase
                res = {{32{w[31]}}, w}; // word results widen from bit 31
            end
            default: ok = 1'b0; // loads, stores, branches, system other than ebreak
        endcase
    endfunction

    task automatic apply_issue(input logic [31:0] ins);
        logic [XLEN-1:0] res;
        logic            ok;
        if (!model_halted) begin // halted core drops issues
            if (ins == 32'h0010_0073) begin
                model_retired = model_retired + 32'd1; // ebreak retires
                model_halted  = 1'b1;
                since_entry   = 0;
            end else begin
                isa_exec(ins, model_regs[ins[19:15]], model_regs[ins[24:20]], res, ok);
                if (!ok) begin
                    model_illegal = 1'b1;
                end else begin
                    model_retired = model_retired + 32'd1;
                    since_entry   = 0;
                    if (ins[11:7] != 5'd0) begin
                        model_regs[ins[11:7]] = res;
                    end
                end
            end
        end
    endtask

    task automatic check_read();
        logic [XLEN-1:0] expect_val;
        logic [XLEN-1:0] mask;
        logic            busy_exp;
        mask       = '1;
        expect_val = '0; // unmapped reads give zero
        if (adr == STATUS_ADR) begin
            // status is captured one edge before ack
            // so an instr issued two or three edges ago sits in decode or execute
            busy_exp   = (since_entry == 2 || since_entry == 3);
            expect_val = {model_retired, 29'b0, model_illegal, model_halted, busy_exp};
            if (busy_exp) begin
                mask = 64'h5; // retired and halted lag until write-back
            end
        end else if (adr >= REGS_BASE && adr[2:0] == 3'b000) begin
            expect_val = model_regs[adr[REG_ADDR_W+2:3]];
        end
        checks = checks + 1;
        if ((dat_r & mask) !== (expect_val & mask)) begin
            errors = errors + 1;
            $display("error at %0t: read of 0x%03h returned 0x%016h, expected 0x%016h",
                     $time, adr, dat_r, expect_val);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model_regs[i] = '0;
            end
            model_halted  = 1'b0;
            model_illegal = 1'b0;
            model_retired = '0;
            since_entry   = 4;
            req_wait      = 0;
            checks        = 0;
            errors        = 0;
        end else begin
            if (since_entry < 4) begin
                since_entry = since_entry + 1;
            end
            // ack answers one edge after the request opens, for one edge
            if (ack !== (cyc && stb && req_wait == 1)) begin
                errors = errors + 1;
                $display("error at %0t: ack was %b, expected %b",
                         $time, ack, cyc && stb && req_wait == 1);
            end
            if (cyc && stb && ack) begin // transfer lands on this edge
                if (!we) begin
                    check_read();
                end else if (adr == ISSUE_ADR) begin
                    apply_issue(dat_w[31:0]);
                end
            end
            req_wait = (cyc && stb && !ack) ? req_wait + 1 : 0;
        end
    end

endmodule

/* tb_rvs_core.sv */
`timescale 1ns/1ps

module tb_rvs_core;
    import rvs_pkg::*;

    localparam int N_RANDOM  = 200;
    localparam int N_WORD    = 60;
    localparam int N_CHAINS  = 4;
    localparam int CHAIN_LEN = 8;
    // issues per test plus six dumps of 32 regs with a few status polls
    localparam int PLANNED_XFERS = 62 + N_RANDOM + 16 + N_WORD + N_CHAINS * CHAIN_LEN
                                   + 9 + 4 + 9 + 6 * 40;
    localparam int TIMEOUT_NS = (4 * PLANNED_XFERS + 500) * 4; // 4 ns clock

    logic                clk;
    logic                rst_n;
    logic                cyc, stb, we, ack;
    logic [WB_ADR_W-1:0] adr;
    logic [XLEN-1:0]     dat_w, dat_r;
    logic [31:0]         lcg_state;
    int                  checks, errors;

    rvs_core_top rvs_core_top_i (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
    );

    tb_rvs_checker tb_rvs_checker_i (
        .clk, .rst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack, .checks, .errors
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15); // low LCG bits cycle fast
    endfunction

    function automatic logic [4:0] rand_reg(); // x1..x31
        return 5'(lcg_next() % 31 + 1);
    endfunction

    function automatic logic [31:0] enc(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc}; // I-type, R-type with imm = {funct7, rs2}
    endfunction

    // random legal ALU op, word flag picks the *W groups
    function automatic logic [31:0] rand_op(input logic word, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = lcg_next();
        f3  = word ? ((r[1:0] == 2'd0) ? 3'd0 : (r[1:0] == 2'd1) ? 3'd1 : 3'd5) : r[2:0];
        f7  = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00; // sub, sra
        imm = r[31:20];
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = word ? {f7, r[24:20]} : {f7[6:1], r[25:20]};
        end
        if (r[4]) begin
            r = enc(imm, rs1, f3, rd, word ? OPC_OP_IMM_32 : OPC_OP_IMM);
        end else begin
            r = enc({f7, rs2}, rs1, f3, rd, word ? OPC_OP_32 : OPC_OP);
        end
        return r;
    endfunction

    // one bus transfer, entered and left on a falling edge
    task automatic bus_xfer(input logic wr, input logic [WB_ADR_W-1:0] a,
                            input logic [XLEN-1:0] wd, output logic [XLEN-1:0] rdata);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wd;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        rdata = dat_r; // valid with ack
        @(negedge clk); // ack edge passed
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic issue(input logic [31:0] ins);
        logic [XLEN-1:0] unused_rd;
        bus_xfer(1'b1, ISSUE_ADR, {32'h0, ins}, unused_rd);
    endtask

    // drain, then dump all registers; checker compares each read
    task automatic check_state();
        logic [XLEN-1:0] d;
        d = 64'h1;
        while (d[0]) begin
            bus_xfer(1'b0, STATUS_ADR, '0, d);
        end
        for (int n = 0; n < NUM_REGS; n++) begin
            bus_xfer(1'b0, REGS_BASE + WB_ADR_W'(8 * n), '0, d);
        end
        bus_xfer(1'b0, 9'h010, '0, d); // unmapped
    endtask

    initial begin
        logic [XLEN-1:0] d;
        logic [4:0]      prev, rd;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        lcg_state = 32'd77;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 1; i < NUM_REGS; i++) begin // lui + addi seeds every reg
            d = {32'h0, lcg_next()};
            issue({d[31:12], 5'(i), OPC_LUI});
            issue(enc(d[11:0], 5'(i), 3'd0, 5'(i), OPC_OP_IMM));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            issue(rand_op(1'b0, rand_reg(), rand_reg(), rand_reg()));
        end
        check_state();

        for (int i = 1; i <= 8; i++) begin // x1..x8 get bit 31 set
            d = {32'h0, lcg_next()};
            issue({1'b1, d[30:12], 5'(i), OPC_LUI});
            issue(enc({1'b0, d[10:0]}, 5'(i), 3'd6, 5'(i), OPC_OP_IMM)); // ori
        end
        for (int i = 0; i < N_WORD; i++) begin
            d = {32'h0, lcg_next()};
            issue(rand_op(1'b1, 5'(d[2:0] + 1), 5'(d[5:3] + 1), 5'(9 + d[31:8] % 23)));
        end
        check_state();

        for (int c = 0; c < N_CHAINS; c++) begin // each op reads the last result
            prev = rand_reg();
            for (int k = 0; k < CHAIN_LEN; k++) begin
                rd = rand_reg();
                issue(rand_op((k % 2) == 1, prev, prev, rd));
                prev = rd;
            end
        end
        check_state();

        issue({20'habcde, 5'd0, OPC_LUI}); // x0 targets
        for (int i = 0; i < 8; i++) begin
            issue(rand_op((i % 2) == 1, rand_reg(), rand_reg(), 5'd0));
        end
        check_state();

        issue(enc(12'h010, 5'd1, 3'd3, 5'd2, 7'b0000011)); // ld
        issue(enc({7'h01, 5'd3}, 5'd4, 3'd0, 5'd5, OPC_OP)); // mul
        issue(enc(12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM)); // ecall
        issue(rand_op(1'b0, rand_reg(), rand_reg(), rand_reg()));
        check_state();

        issue(rand_op(1'b0, rand_reg(), rand_reg(), rand_reg()));
        issue(rand_op(1'b1, rand_reg(), rand_reg(), rand_reg()));
        issue(32'h0010_0073); // ebreak
        for (int i = 0; i < 6; i++) begin
            issue(rand_op((i % 2) == 1, rand_reg(), rand_reg(), rand_reg()));
        end
        check_state();

        $display("checks: %0d reads compared, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST PASSED");
        end else begin
            if (checks == 0) begin
                $display("the checker compared no reads");
            end
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin // watchdog
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns before all tests finished", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* src.f */
rvs_pkg.sv
rvs_regfile.sv
rvs_decode.sv
rvs_execute.sv
rvs_writeback.sv
rvs_core_top.sv
tb_rvs_checker.sv
tb_rvs_core.sv

/* Makefile */
# Verilator build and run of the core testbench

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_rvs_core -f src.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
